// File: project.f
+incdir+rtl
+incdir+sim
rtl/host_pkg.sv
rtl/host_axil_slave.sv
rtl/llc_ctrl_regs.sv
rtl/host_mailbox.sv
rtl/host_domain.sv
sim/tb_host_domain.sv

// File: run.sh
#!/bin/sh
# Build and run the host domain regression with Verilator
set -e
cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --assert -Wno-fatal --top-module tb_host_domain -f project.f

./obj_dir/Vtb_host_domain > sim.log 2>&1
cat sim.log

if grep -q "Regression failed" sim.log; then
  exit 1
fi
exit 0

// File: sim/tb_host_tasks.svh
// Host domain testbench tasks
`ifndef TB_HOST_TASKS_SVH
`define TB_HOST_TASKS_SVH

// Galois LFSR with polynomial x^32 + x^22 + x^2 + x + 1
function automatic logic [31:0] lfsr_next(input logic [31:0] s);
  return (s >> 1) ^ (s[0] ? 32'h80200003 : 32'h0);
endfunction

// One LFSR step per bit taken
task automatic rand_bits(input int nbits, output host_pkg::data_t val);
  val = '0;
  for (int i = 0; i < nbits; i++) begin
    val = (val << 1) | host_pkg::data_t'(lfsr_q[0]);
    lfsr_q = lfsr_next(lfsr_q);
  end
endtask

task automatic report_failure(input string msg);
  other_errors++;
  $display("%s at %0t", msg, $time);
endtask

task automatic check_data(input string name, input host_pkg::data_t exp,
                          input host_pkg::data_t act);
  checks++;
  if (act !== exp) begin
    value_errors++;
    $display("error %s: expected 0x%08h, actual 0x%08h", name, exp, act);
  end
endtask

task automatic check_resp(input string name, input host_pkg::resp_t exp,
                          input host_pkg::resp_t act);
  checks++;
  if (act !== exp) begin
    value_errors++;
    $display("error %s: expected resp %0d, actual resp %0d", name, exp, act);
  end
endtask

task automatic check_window(input string name, input host_pkg::llc_window_t exp,
                            input host_pkg::llc_window_t act);
  checks++;
  if (act !== exp) begin
    value_errors++;
    $display("error %s: expected 0x%024h, actual 0x%024h", name, exp, act);
  end
endtask

task automatic check_irq(input string name, input logic exp, input logic act);
  checks++;
  if (act !== exp) begin
    value_errors++;
    $display("error %s: expected %b, actual %b", name, exp, act);
  end
endtask

// Handshake on the rising edge, response one cycle later
task automatic axil_write(input host_pkg::addr_t addr, input host_pkg::data_t data,
                          input host_pkg::strb_t strb, input int hold,
                          output host_pkg::resp_t resp);
  int   cycles;
  logic accepted;
  @(negedge clk_i);
  awaddr_i  = addr;
  awvalid_i = 1'b1;
  wdata_i   = data;
  wstrb_i   = strb;
  wvalid_i  = 1'b1;
  cycles = 0;
  do begin
    @(posedge clk_i);
    accepted = awready_o && wready_o;
    cycles++;
  end while (!accepted && cycles < TIMEOUT_CYCLES);
  @(negedge clk_i);
  awvalid_i = 1'b0;
  wvalid_i  = 1'b0;
  resp = bresp_o;
  if (!accepted) begin
    report_failure($sformatf("Write address or data channel hung at 0x%08h", addr));
    resp = '1;
    return;
  end
  if (!bvalid_o) begin
    report_failure("Write response did not rise one cycle after acceptance");
    resp = '1;
    return;
  end
  for (int i = 0; i < hold; i++) begin
    @(negedge clk_i);
    if (!bvalid_o || bresp_o !== resp) begin
      report_failure("Write response changed while bready was low");
    end
  end
  bready_i = 1'b1;
  cycles = 0;
  do begin
    @(negedge clk_i);
    cycles++;
  end while (bvalid_o && cycles < TIMEOUT_CYCLES);
  bready_i = 1'b0;
  if (bvalid_o) begin
    report_failure("Write response channel hung with bready high");
  end
endtask

task automatic axil_read(input host_pkg::addr_t addr, input int hold,
                         output host_pkg::data_t data, output host_pkg::resp_t resp);
  int   cycles;
  logic accepted;
  @(negedge clk_i);
  araddr_i  = addr;
  arvalid_i = 1'b1;
  cycles = 0;
  do begin
    @(posedge clk_i);
    accepted = arready_o;
    cycles++;
  end while (!accepted && cycles < TIMEOUT_CYCLES);
  @(negedge clk_i);
  arvalid_i = 1'b0;
  data = rdata_o;
  resp = rresp_o;
  if (!accepted) begin
    report_failure($sformatf("Read address channel hung at 0x%08h", addr));
    resp = '1;
    return;
  end
  if (!rvalid_o) begin
    report_failure("Read data did not rise one cycle after acceptance");
    resp = '1;
    return;
  end
  for (int i = 0; i < hold; i++) begin
    @(negedge clk_i);
    if (!rvalid_o || rdata_o !== data || rresp_o !== resp) begin
      report_failure("Read response changed while rready was low");
    end
  end
  rready_i = 1'b1;
  cycles = 0;
  do begin
    @(negedge clk_i);
    cycles++;
  end while (rvalid_o && cycles < TIMEOUT_CYCLES);
  rready_i = 1'b0;
  if (rvalid_o) begin
    report_failure("Read response channel hung with rready high");
  end
endtask

task automatic write_and_check(input host_pkg::addr_t addr, input host_pkg::data_t data,
                               input host_pkg::strb_t strb, input host_pkg::resp_t exp_resp,
                               input string name, input int hold);
  host_pkg::resp_t resp;
  axil_write(addr, data, strb, hold, resp);
  check_resp($sformatf("%s @0x%03h", name, addr), exp_resp, resp);
endtask

task automatic read_and_check(input host_pkg::addr_t addr, input host_pkg::data_t exp,
                              input host_pkg::resp_t exp_resp, input string name,
                              input int hold);
  host_pkg::data_t rdat;
  host_pkg::resp_t resp;
  axil_read(addr, hold, rdat, resp);
  check_resp($sformatf("%s @0x%03h", name, addr), exp_resp, resp);
  check_data($sformatf("%s @0x%03h", name, addr), exp, rdat);
endtask

`endif

// File: sim/tb_host_domain.sv
// Host domain testbench
`timescale 1ns/1ps
`include "host_defs.svh"

module tb_host_domain;

  localparam int TIMEOUT_CYCLES = 200;
  localparam host_pkg::off_t WIN_OFF [3] = '{`LLC_CACHE_START, `LLC_CACHE_END, `LLC_SPM_START};
  localparam host_pkg::off_t CNT_OFF [4] = '{`LLC_RD_HIT, `LLC_RD_MISS, `LLC_WR_HIT, `LLC_WR_MISS};
  localparam host_pkg::off_t IRQ_OFF [3] = '{`MBOX_DOORBELL, `MBOX_COMPLETION, `MBOX_H2C};

  logic                  clk_i;
  logic                  arst_n_i;
  host_pkg::addr_t       awaddr_i;
  logic                  awvalid_i;
  logic                  awready_o;
  host_pkg::data_t       wdata_i;
  host_pkg::strb_t       wstrb_i;
  logic                  wvalid_i;
  logic                  wready_o;
  host_pkg::resp_t       bresp_o;
  logic                  bvalid_o;
  logic                  bready_i;
  host_pkg::addr_t       araddr_i;
  logic                  arvalid_i;
  logic                  arready_o;
  host_pkg::data_t       rdata_o;
  host_pkg::resp_t       rresp_o;
  logic                  rvalid_o;
  logic                  rready_i;
  host_pkg::llc_events_t llc_events_i;
  host_pkg::llc_window_t llc_window_o;
  logic                  c2h_irq_i;
  logic                  h2c_irq_o;
  logic                  doorbell_irq_o;
  logic                  completion_irq_o;

  int              checks;
  int              value_errors;
  int              other_errors;
  logic [31:0]     lfsr_q;
  // Expected register state
  host_pkg::data_t win_exp [3];
  logic [2:0]      irq_exp;

  host_domain DUT (.*);

  `include "tb_host_tasks.svh"

  always #5 clk_i = ~clk_i;

  function automatic host_pkg::addr_t llc_addr(input host_pkg::off_t off);
    return host_pkg::addr_t'(off);
  endfunction

  function automatic host_pkg::addr_t mbox_addr(input host_pkg::off_t off);
    return host_pkg::addr_t'(off) | (host_pkg::addr_t'(1) << `HOST_SEL_BIT);
  endfunction

  function automatic host_pkg::data_t apply_strobes(input host_pkg::data_t old_val,
                                                    input host_pkg::data_t new_val,
                                                    input host_pkg::strb_t strb);
    host_pkg::data_t mask;
    mask = {{8{strb[3]}}, {8{strb[2]}}, {8{strb[1]}}, {8{strb[0]}}};
    return (old_val & ~mask) | (new_val & mask);
  endfunction

  function automatic host_pkg::llc_window_t window_expected();
    return '{cache_start: win_exp[0], cache_end: win_exp[1], spm_start: win_exp[2]};
  endfunction

  task automatic check_all_irqs(input string name);
    check_irq($sformatf("%s doorbell", name), irq_exp[0], doorbell_irq_o);
    check_irq($sformatf("%s completion", name), irq_exp[1], completion_irq_o);
    check_irq($sformatf("%s h2c", name), irq_exp[2], h2c_irq_o);
  endtask

  task automatic test_reset();
    check_all_irqs("reset");
    check_window("reset window", '0, llc_window_o);
    for (int i = 0; i < 3; i++) begin
      read_and_check(llc_addr(WIN_OFF[i]), '0, `RESP_OKAY, "reset window read", 0);
      read_and_check(mbox_addr(IRQ_OFF[i]), '0, `RESP_OKAY, "reset mailbox read", 0);
    end
    for (int i = 0; i < 4; i++) begin
      read_and_check(llc_addr(CNT_OFF[i]), '0, `RESP_OKAY, "reset counter read", 0);
    end
    read_and_check(mbox_addr(`MBOX_C2H_STATUS), '0, `RESP_OKAY, "reset c2h read", 0);
  endtask

  task automatic test_window();
    host_pkg::data_t wdat;
    host_pkg::data_t rnd;
    host_pkg::strb_t strb;
    // First pass with all strobes, then random byte strobes
    for (int pass = 0; pass < 4; pass++) begin
      for (int r = 0; r < 3; r++) begin
        rand_bits(32, wdat);
        rand_bits(4, rnd);
        strb = rnd[3:0];
        if (pass == 0) begin
          strb = '1;
        end
        write_and_check(llc_addr(WIN_OFF[r]), wdat, strb, `RESP_OKAY, "window write", 0);
        win_exp[r] = apply_strobes(win_exp[r], wdat, strb);
        read_and_check(llc_addr(WIN_OFF[r]), win_exp[r], `RESP_OKAY, "window readback", 0);
      end
      check_window("window output", window_expected(), llc_window_o);
    end
  endtask

  task automatic test_counters();
    int              n [4];
    host_pkg::data_t rnd;
    for (int i = 0; i < 4; i++) begin
      rand_bits(4, rnd);
      n[i] = int'(rnd[3:0]) + i + 1;
    end
    // Strobe i is high for the first n[i] cycles
    for (int k = 0; k < 20; k++) begin
      @(negedge clk_i);
      llc_events_i.rd_hit  = (k < n[0]);
      llc_events_i.rd_miss = (k < n[1]);
      llc_events_i.wr_hit  = (k < n[2]);
      llc_events_i.wr_miss = (k < n[3]);
    end
    @(negedge clk_i);
    llc_events_i = '0;
    for (int i = 0; i < 4; i++) begin
      read_and_check(llc_addr(CNT_OFF[i]), host_pkg::data_t'(n[i]), `RESP_OKAY,
                     "event count", 0);
    end
    for (int i = 0; i < 4; i++) begin
      rand_bits(32, rnd);
      write_and_check(llc_addr(CNT_OFF[i]), rnd, '1, `RESP_OKAY, "counter clear", 0);
      read_and_check(llc_addr(CNT_OFF[i]), '0, `RESP_OKAY, "cleared count", 0);
    end
  endtask

  task automatic test_mailbox();
    for (int v = 1; v >= 0; v--) begin
      for (int i = 0; i < 3; i++) begin
        write_and_check(mbox_addr(IRQ_OFF[i]), host_pkg::data_t'(v), 4'h1, `RESP_OKAY,
                        "irq write", 0);
        irq_exp[i] = v[0];
        check_all_irqs("irq output");
        read_and_check(mbox_addr(IRQ_OFF[i]), host_pkg::data_t'(v), `RESP_OKAY,
                       "irq readback", 0);
      end
    end
    // One-cycle pulse from the cluster
    @(negedge clk_i);
    c2h_irq_i = 1'b1;
    @(negedge clk_i);
    c2h_irq_i = 1'b0;
    read_and_check(mbox_addr(`MBOX_C2H_STATUS), 32'h1, `RESP_OKAY, "c2h latched", 0);
    write_and_check(mbox_addr(`MBOX_C2H_STATUS), '0, '1, `RESP_OKAY, "c2h write zero", 0);
    read_and_check(mbox_addr(`MBOX_C2H_STATUS), 32'h1, `RESP_OKAY, "c2h kept", 0);
    write_and_check(mbox_addr(`MBOX_C2H_STATUS), 32'h1, '1, `RESP_OKAY, "c2h clear", 0);
    read_and_check(mbox_addr(`MBOX_C2H_STATUS), '0, `RESP_OKAY, "c2h cleared", 0);
  endtask

  task automatic test_errors();
    host_pkg::off_t  bad_llc [3];
    host_pkg::off_t  bad_mbox [3];
    host_pkg::data_t wdat;
    bad_llc  = '{8'h0C, 8'h20, 8'hFC};
    bad_mbox = '{8'h10, 8'h40, 8'hFC};
    for (int i = 0; i < 3; i++) begin
      rand_bits(32, wdat);
      write_and_check(llc_addr(bad_llc[i]), wdat, '1, `RESP_SLVERR, "llc unmapped write", 0);
      read_and_check(llc_addr(bad_llc[i]), '0, `RESP_SLVERR, "llc unmapped read", 0);
      write_and_check(mbox_addr(bad_mbox[i]), wdat | 32'h1, '1, `RESP_SLVERR,
                      "mbox unmapped write", 0);
      read_and_check(mbox_addr(bad_mbox[i]), '0, `RESP_SLVERR, "mbox unmapped read", 0);
    end
    check_window("window after errors", window_expected(), llc_window_o);
    check_all_irqs("irqs after errors");
    for (int r = 0; r < 3; r++) begin
      read_and_check(llc_addr(WIN_OFF[r]), win_exp[r], `RESP_OKAY, "window after errors", 0);
    end
    read_and_check(mbox_addr(`MBOX_C2H_STATUS), '0, `RESP_OKAY, "c2h after errors", 0);
    // Responses held by a slow master
    rand_bits(32, wdat);
    write_and_check(llc_addr(`LLC_CACHE_END), wdat, '1, `RESP_OKAY, "held write", 6);
    win_exp[1] = wdat;
    read_and_check(llc_addr(`LLC_CACHE_END), wdat, `RESP_OKAY, "held read", 6);
    write_and_check(mbox_addr(8'h40), wdat, '1, `RESP_SLVERR, "held error write", 4);
    read_and_check(mbox_addr(8'h40), '0, `RESP_SLVERR, "held error read", 4);
    check_window("window after hold", window_expected(), llc_window_o);
  endtask

  initial begin
    clk_i        = 1'b0;
    arst_n_i     = 1'b0;
    awaddr_i     = '0;
    awvalid_i    = 1'b0;
    wdata_i      = '0;
    wstrb_i      = '0;
    wvalid_i     = 1'b0;
    bready_i     = 1'b0;
    araddr_i     = '0;
    arvalid_i    = 1'b0;
    rready_i     = 1'b0;
    llc_events_i = '0;
    c2h_irq_i    = 1'b0;
    checks       = 0;
    value_errors = 0;
    other_errors = 0;
    lfsr_q       = 32'd4;
    irq_exp      = '0;
    foreach (win_exp[i]) begin
      win_exp[i] = '0;
    end
    repeat (5) @(posedge clk_i);
    @(negedge clk_i);
    arst_n_i = 1'b1;

    test_reset();
    test_window();
    test_counters();
    test_mailbox();
    test_errors();

    $display("Checks %0d, value errors %0d, other errors %0d",
             checks, value_errors, other_errors);
    if (value_errors == 0 && other_errors == 0) begin
      $display("Regression passed");
    end else begin
      $display("Regression failed");
    end
    $finish;
  end

endmodule

// File: rtl/host_domain.sv
// Host domain control plane top
`timescale 1ns/1ps

module host_domain (
  input  logic                   clk_i,
  input  logic                   arst_n_i,
  input  host_pkg::addr_t        awaddr_i,
  input  logic                   awvalid_i,
  output logic                   awready_o,
  input  host_pkg::data_t        wdata_i,
  input  host_pkg::strb_t        wstrb_i,
  input  logic                   wvalid_i,
  output logic                   wready_o,
  output host_pkg::resp_t        bresp_o,
  output logic                   bvalid_o,
  input  logic                   bready_i,
  input  host_pkg::addr_t        araddr_i,
  input  logic                   arvalid_i,
  output logic                   arready_o,
  output host_pkg::data_t        rdata_o,
  output host_pkg::resp_t        rresp_o,
  output logic                   rvalid_o,
  input  logic                   rready_i,
  input  host_pkg::llc_events_t  llc_events_i,
  output host_pkg::llc_window_t  llc_window_o,
  input  logic                   c2h_irq_i,
  output logic                   h2c_irq_o,
  output logic                   doorbell_irq_o,
  output logic                   completion_irq_o
);

  host_pkg::reg_req_t llc_req;
  host_pkg::reg_rsp_t llc_rsp;
  host_pkg::reg_req_t mbox_req;
  host_pkg::reg_rsp_t mbox_rsp;

  host_axil_slave i_axil_slave (
    .clk_i      ( clk_i     ),
    .arst_n_i   ( arst_n_i  ),
    .awaddr_i   ( awaddr_i  ),
    .awvalid_i  ( awvalid_i ),
    .awready_o  ( awready_o ),
    .wdata_i    ( wdata_i   ),
    .wstrb_i    ( wstrb_i   ),
    .wvalid_i   ( wvalid_i  ),
    .wready_o   ( wready_o  ),
    .bresp_o    ( bresp_o   ),
    .bvalid_o   ( bvalid_o  ),
    .bready_i   ( bready_i  ),
    .araddr_i   ( araddr_i  ),
    .arvalid_i  ( arvalid_i ),
    .arready_o  ( arready_o ),
    .rdata_o    ( rdata_o   ),
    .rresp_o    ( rresp_o   ),
    .rvalid_o   ( rvalid_o  ),
    .rready_i   ( rready_i  ),
    .llc_req_o  ( llc_req   ),
    .llc_rsp_i  ( llc_rsp   ),
    .mbox_req_o ( mbox_req  ),
    .mbox_rsp_i ( mbox_rsp  )
  );

  llc_ctrl_regs i_llc_ctrl_regs (
    .clk_i        ( clk_i        ),
    .arst_n_i     ( arst_n_i     ),
    .req_i        ( llc_req      ),
    .rsp_o        ( llc_rsp      ),
    .llc_events_i ( llc_events_i ),
    .llc_window_o ( llc_window_o )
  );

  host_mailbox i_host_mailbox (
    .clk_i            ( clk_i            ),
    .arst_n_i         ( arst_n_i         ),
    .req_i            ( mbox_req         ),
    .rsp_o            ( mbox_rsp         ),
    .c2h_irq_i        ( c2h_irq_i        ),
    .doorbell_irq_o   ( doorbell_irq_o   ),
    .completion_irq_o ( completion_irq_o ),
    .h2c_irq_o        ( h2c_irq_o        )
  );

endmodule

// File: rtl/host_mailbox.sv
// Host mailbox interrupt registers
`timescale 1ns/1ps
`include "host_defs.svh"

module host_mailbox (
  input  logic                clk_i,
  input  logic                arst_n_i,
  input  host_pkg::reg_req_t  req_i,
  output host_pkg::reg_rsp_t  rsp_o,
  input  logic                c2h_irq_i,
  output logic                doorbell_irq_o,
  output logic                completion_irq_o,
  output logic                h2c_irq_o
);

  // Bit 0 of doorbell, completion and h2c, in that order
  logic [2:0] ctrl_q;
  logic [2:0] ctrl_wr;
  logic       c2h_q;
  logic       c2h_clr;
  logic       wr_bit0;

  assign wr_bit0 = req_i.valid && req_i.write && req_i.wstrb[0];

  assign ctrl_wr[0] = wr_bit0 && (req_i.offset == `MBOX_DOORBELL);
  assign ctrl_wr[1] = wr_bit0 && (req_i.offset == `MBOX_COMPLETION);
  assign ctrl_wr[2] = wr_bit0 && (req_i.offset == `MBOX_H2C);
  assign c2h_clr    = wr_bit0 && (req_i.offset == `MBOX_C2H_STATUS) && req_i.wdata[0];

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      ctrl_q <= '0;
    end else begin
      for (int i = 0; i < 3; i++) begin
        if (ctrl_wr[i]) begin
          ctrl_q[i] <= req_i.wdata[0];
        end
      end
    end
  end

  // A new interrupt wins over the clear
  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      c2h_q <= 1'b0;
    end else if (c2h_irq_i) begin
      c2h_q <= 1'b1;
    end else if (c2h_clr) begin
      c2h_q <= 1'b0;
    end
  end

  always_comb begin
    rsp_o.rdata = '0;
    rsp_o.error = 1'b0;
    case (req_i.offset)
      `MBOX_DOORBELL:   rsp_o.rdata[0] = ctrl_q[0];
      `MBOX_COMPLETION: rsp_o.rdata[0] = ctrl_q[1];
      `MBOX_H2C:        rsp_o.rdata[0] = ctrl_q[2];
      `MBOX_C2H_STATUS: rsp_o.rdata[0] = c2h_q;
      default:          rsp_o.error = 1'b1;
    endcase
  end

  assign doorbell_irq_o   = ctrl_q[0];
  assign completion_irq_o = ctrl_q[1];
  assign h2c_irq_o        = ctrl_q[2];

endmodule

// File: rtl/llc_ctrl_regs.sv
// LLC window and event counter registers
`timescale 1ns/1ps
`include "host_defs.svh"

module llc_ctrl_regs (
  input  logic                   clk_i,
  input  logic                   arst_n_i,
  input  host_pkg::reg_req_t     req_i,
  output host_pkg::reg_rsp_t     rsp_o,
  input  host_pkg::llc_events_t  llc_events_i,
  output host_pkg::llc_window_t  llc_window_o
);

  host_pkg::llc_window_t window_q;
  host_pkg::data_t       cnt_q [4];
  logic [3:0]            ev;
  logic [3:0]            cnt_clr;
  logic                  wr_en;

  // Replace only the strobed bytes
  function automatic host_pkg::data_t merge_bytes(input host_pkg::data_t old_val,
                                                  input host_pkg::data_t new_val,
                                                  input host_pkg::strb_t strb);
    host_pkg::data_t res;
    res = old_val;
    for (int b = 0; b < `HOST_DW/8; b++) begin
      if (strb[b]) begin
        res[8*b +: 8] = new_val[8*b +: 8];
      end
    end
    return res;
  endfunction

  assign wr_en = req_i.valid && req_i.write;

  // Counter order follows the offsets
  assign ev = {llc_events_i.wr_miss, llc_events_i.wr_hit,
               llc_events_i.rd_miss, llc_events_i.rd_hit};

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      window_q <= '0;
    end else if (wr_en) begin
      case (req_i.offset)
        `LLC_CACHE_START: begin
          window_q.cache_start <= merge_bytes(window_q.cache_start, req_i.wdata, req_i.wstrb);
        end
        `LLC_CACHE_END: begin
          window_q.cache_end <= merge_bytes(window_q.cache_end, req_i.wdata, req_i.wstrb);
        end
        `LLC_SPM_START: begin
          window_q.spm_start <= merge_bytes(window_q.spm_start, req_i.wdata, req_i.wstrb);
        end
        default: ;
      endcase
    end
  end

  for (genvar i = 0; i < 4; i++) begin : g_cnt
    assign cnt_clr[i] = wr_en && (req_i.offset == host_pkg::off_t'(`LLC_RD_HIT + 4*i));

    // Clear beats a strobe in the same cycle
    always_ff @(posedge clk_i or negedge arst_n_i) begin
      if (!arst_n_i) begin
        cnt_q[i] <= '0;
      end else if (cnt_clr[i]) begin
        cnt_q[i] <= '0;
      end else if (ev[i] && (cnt_q[i] != '1)) begin
        cnt_q[i] <= cnt_q[i] + 1'b1;
      end
    end

    a_cnt_mono: assert property (@(posedge clk_i) disable iff (!arst_n_i)
      !cnt_clr[i] |=> cnt_q[i] >= $past(cnt_q[i]))
      else $error("LLC event counter %0d went down without a clear", i);
  end

  always_comb begin
    rsp_o.rdata = '0;
    rsp_o.error = 1'b0;
    case (req_i.offset)
      `LLC_CACHE_START: rsp_o.rdata = window_q.cache_start;
      `LLC_CACHE_END:   rsp_o.rdata = window_q.cache_end;
      `LLC_SPM_START:   rsp_o.rdata = window_q.spm_start;
      `LLC_RD_HIT:      rsp_o.rdata = cnt_q[0];
      `LLC_RD_MISS:     rsp_o.rdata = cnt_q[1];
      `LLC_WR_HIT:      rsp_o.rdata = cnt_q[2];
      `LLC_WR_MISS:     rsp_o.rdata = cnt_q[3];
      default:          rsp_o.error = 1'b1;
    endcase
  end

  assign llc_window_o = window_q;

endmodule

// File: rtl/host_axil_slave.sv
// AXI4-Lite configuration slave
`timescale 1ns/1ps
`include "host_defs.svh"

module host_axil_slave (
  input  logic                clk_i,
  input  logic                arst_n_i,
  input  host_pkg::addr_t     awaddr_i,
  input  logic                awvalid_i,
  output logic                awready_o,
  input  host_pkg::data_t     wdata_i,
  input  host_pkg::strb_t     wstrb_i,
  input  logic                wvalid_i,
  output logic                wready_o,
  output host_pkg::resp_t     bresp_o,
  output logic                bvalid_o,
  input  logic                bready_i,
  input  host_pkg::addr_t     araddr_i,
  input  logic                arvalid_i,
  output logic                arready_o,
  output host_pkg::data_t     rdata_o,
  output host_pkg::resp_t     rresp_o,
  output logic                rvalid_o,
  input  logic                rready_i,
  output host_pkg::reg_req_t  llc_req_o,
  input  host_pkg::reg_rsp_t  llc_rsp_i,
  output host_pkg::reg_req_t  mbox_req_o,
  input  host_pkg::reg_rsp_t  mbox_rsp_i
);

  host_pkg::wr_state_e wr_state_q;
  host_pkg::rd_state_e rd_state_q;
  host_pkg::reg_req_t  wr_req;
  host_pkg::reg_req_t  rd_req;
  host_pkg::reg_rsp_t  wr_rsp;
  host_pkg::reg_rsp_t  rd_rsp;
  host_pkg::resp_t     bresp_q;
  host_pkg::resp_t     rresp_q;
  host_pkg::data_t     rdata_q;
  logic                wr_sel;
  logic                rd_sel;
  logic                wr_go;
  logic                rd_go;
  logic                wr_conflict;

  assign wr_sel = awaddr_i[`HOST_SEL_BIT];
  assign rd_sel = araddr_i[`HOST_SEL_BIT];

  assign rd_go = (rd_state_q == host_pkg::RD_IDLE) && arvalid_i;

  // A block has one request port, so a read to the same block goes first
  // and the write follows a cycle later, seeing the pre-write value
  assign wr_conflict = rd_go && (rd_sel == wr_sel);
  assign wr_go = (wr_state_q == host_pkg::WR_IDLE) && awvalid_i && wvalid_i && !wr_conflict;

  // AW and W only ever complete together
  assign awready_o = wr_go;
  assign wready_o  = wr_go;
  assign arready_o = (rd_state_q == host_pkg::RD_IDLE);

  assign wr_req = '{valid: 1'b1, write: 1'b1, offset: awaddr_i[`HOST_OFF_W-1:0],
                    wdata: wdata_i, wstrb: wstrb_i};
  assign rd_req = '{valid: 1'b1, write: 1'b0, offset: araddr_i[`HOST_OFF_W-1:0],
                    wdata: '0, wstrb: '0};

  // Route to the selected block
  always_comb begin
    llc_req_o  = '0;
    mbox_req_o = '0;
    if (wr_go) begin
      if (wr_sel) begin
        mbox_req_o = wr_req;
      end else begin
        llc_req_o = wr_req;
      end
    end
    if (rd_go) begin
      if (rd_sel) begin
        mbox_req_o = rd_req;
      end else begin
        llc_req_o = rd_req;
      end
    end
  end

  assign wr_rsp = wr_sel ? mbox_rsp_i : llc_rsp_i;
  assign rd_rsp = rd_sel ? mbox_rsp_i : llc_rsp_i;

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      wr_state_q <= host_pkg::WR_IDLE;
    end else begin
      case (wr_state_q)
        host_pkg::WR_IDLE: if (wr_go) wr_state_q <= host_pkg::WR_RESP;
        host_pkg::WR_RESP: if (bready_i) wr_state_q <= host_pkg::WR_IDLE;
        default: wr_state_q <= host_pkg::WR_IDLE;
      endcase
    end
  end

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      rd_state_q <= host_pkg::RD_IDLE;
    end else begin
      case (rd_state_q)
        host_pkg::RD_IDLE: if (rd_go) rd_state_q <= host_pkg::RD_RESP;
        host_pkg::RD_RESP: if (rready_i) rd_state_q <= host_pkg::RD_IDLE;
        default: rd_state_q <= host_pkg::RD_IDLE;
      endcase
    end
  end

  // Response payload, captured on acceptance
  always_ff @(posedge clk_i) begin
    if (wr_go) begin
      bresp_q <= wr_rsp.error ? `RESP_SLVERR : `RESP_OKAY;
    end
    if (rd_go) begin
      rresp_q <= rd_rsp.error ? `RESP_SLVERR : `RESP_OKAY;
      rdata_q <= rd_rsp.error ? '0 : rd_rsp.rdata;
    end
  end

  assign bvalid_o = (wr_state_q == host_pkg::WR_RESP);
  assign bresp_o  = bresp_q;
  assign rvalid_o = (rd_state_q == host_pkg::RD_RESP);
  assign rresp_o  = rresp_q;
  assign rdata_o  = rdata_q;

  a_b_hold: assert property (@(posedge clk_i) disable iff (!arst_n_i)
    bvalid_o && !bready_i |=> bvalid_o && $stable(bresp_o))
    else $error("B response dropped before bready");

  a_r_hold: assert property (@(posedge clk_i) disable iff (!arst_n_i)
    rvalid_o && !rready_i |=> rvalid_o && $stable(rdata_o) && $stable(rresp_o))
    else $error("R response dropped before rready");

endmodule

// File: rtl/host_pkg.sv
// Host control plane types
`include "host_defs.svh"

package host_pkg;

  typedef logic [`HOST_AW-1:0] addr_t;
  typedef logic [`HOST_DW-1:0] data_t;
  typedef logic [`HOST_DW/8-1:0] strb_t;
  typedef logic [`HOST_OFF_W-1:0] off_t;
  typedef logic [1:0] resp_t;

  // Register access towards one block
  typedef struct packed {
    logic  valid;
    logic  write;
    off_t  offset;
    data_t wdata;
    strb_t wstrb;
  } reg_req_t;

  // Same-cycle answer of a block
  typedef struct packed {
    data_t rdata;
    logic  error;
  } reg_rsp_t;

  typedef struct packed {
    data_t cache_start;
    data_t cache_end;
    data_t spm_start;
  } llc_window_t;

  // One strobe per LLC event
  typedef struct packed {
    logic rd_hit;
    logic rd_miss;
    logic wr_hit;
    logic wr_miss;
  } llc_events_t;

  typedef enum logic {
    WR_IDLE,
    WR_RESP
  } wr_state_e;

  typedef enum logic {
    RD_IDLE,
    RD_RESP
  } rd_state_e;

endpackage

// File: rtl/host_defs.svh
// Host control plane definitions
`ifndef HOST_DEFS_SVH
`define HOST_DEFS_SVH

// Bus widths
`define HOST_AW 32
`define HOST_DW 32
`define HOST_OFF_W 8

// Address bit 8 picks the block: 0 is LLC, 1 is mailbox
`define HOST_SEL_BIT 8

// LLC control block
`define LLC_CACHE_START 8'h00
`define LLC_CACHE_END 8'h04
`define LLC_SPM_START 8'h08
`define LLC_RD_HIT 8'h10
`define LLC_RD_MISS 8'h14
`define LLC_WR_HIT 8'h18
`define LLC_WR_MISS 8'h1C

// Host mailbox
`define MBOX_DOORBELL 8'h00
`define MBOX_COMPLETION 8'h04
`define MBOX_H2C 8'h08
`define MBOX_C2H_STATUS 8'h0C

// AXI response codes
`define RESP_OKAY 2'd0
`define RESP_SLVERR 2'd2

`endif
